/* source/dd2_rom_pkg.sv */
// Address map, widths and bus structs shared by the ROM download and read logic; import it
package dd2_rom_pkg;

    typedef logic [21:0] ioctl_addr_t;  // Byte address in the download stream
    typedef logic [21:0] sdram_addr_t;  // 16-bit word address
    typedef logic [31:0] sdram_data_t;  // One read burst
    typedef logic [7:0]  rom_byte_t;

    // Download layout of the ROM set
    localparam ioctl_addr_t MAIN_START = 22'h00000;
    localparam ioctl_addr_t MAIN_END   = 22'h28000;
    localparam ioctl_addr_t SND_START  = 22'h28000;
    localparam ioctl_addr_t SND_END    = 22'h30000;
    localparam ioctl_addr_t CHAR_START = 22'h80000;
    localparam ioctl_addr_t CHAR_END   = 22'h90000;
    localparam ioctl_addr_t PROM_START = 22'h190000;  // Colour priority PROM
    localparam ioctl_addr_t PROM_END   = 22'h190100;

    // Regions sit in SDRAM at the same place, counted in words
    localparam sdram_addr_t MAIN_OFFSET = sdram_addr_t'(MAIN_START >> 1);
    localparam sdram_addr_t SND_OFFSET  = sdram_addr_t'(SND_START >> 1);
    localparam sdram_addr_t CHAR_OFFSET = sdram_addr_t'(CHAR_START >> 1);

    localparam int MAIN_AW = 18;
    localparam int SND_AW  = 15;
    localparam int CHAR_AW = 16;

    // Slot to arbiter
    typedef struct packed {
        logic        valid;
        sdram_addr_t addr;
    } rom_req_t;

    // Arbiter to slot, valid for one cycle
    typedef struct packed {
        logic        valid;
        sdram_data_t data;
    } rom_rsp_t;

    typedef struct packed {
        sdram_addr_t addr;
        rom_byte_t   data;
        logic [1:0]  mask;  // 2'b10 writes the low byte
    } prog_wr_t;

    typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_DATA} arb_state_t;

endpackage

/* source/dd2_prog_map.sv */
// Download write remapper; turns ioctl bytes into SDRAM word writes or PROM strobes
module dd2_prog_map (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ioctl_wr,
    input  dd2_rom_pkg::ioctl_addr_t ioctl_addr,
    input  dd2_rom_pkg::rom_byte_t  ioctl_data,
    input  logic                    sdram_ack,
    output logic                    ioctl_ready,
    output dd2_rom_pkg::prog_wr_t   prog,
    output logic                    prog_we,
    output logic                    prom_we
);
    import dd2_rom_pkg::*;

    logic        pend_sdram;  // Accepted, prog_we rises next edge
    logic        pend_prom;
    logic        map_sdram;
    logic        map_prom;
    sdram_addr_t map_addr;
    logic [1:0]  map_mask;
    logic        take;

    function automatic logic in_region(input ioctl_addr_t a, input ioctl_addr_t lo,
                                       input ioctl_addr_t hi);
        return (a >= lo) && (a < hi);
    endfunction

    function automatic sdram_addr_t to_word(input ioctl_addr_t a, input ioctl_addr_t start,
                                            input sdram_addr_t offset);
        return sdram_addr_t'((a - start) >> 1) + offset;
    endfunction

    // Held off while an SDRAM write waits for its acknowledge
    assign ioctl_ready = !(pend_sdram || pend_prom || prog_we);
    assign take        = ioctl_wr && ioctl_ready;

    always_comb begin
        map_sdram = 1'b0;
        map_prom  = 1'b0;
        map_addr  = '0;
        map_mask  = 2'b00;
        if (in_region(ioctl_addr, MAIN_START, MAIN_END)) begin
            map_sdram = 1'b1;
            map_addr  = to_word(ioctl_addr, MAIN_START, MAIN_OFFSET);
        end else if (in_region(ioctl_addr, SND_START, SND_END)) begin
            map_sdram = 1'b1;
            map_addr  = to_word(ioctl_addr, SND_START, SND_OFFSET);
        end else if (in_region(ioctl_addr, CHAR_START, CHAR_END)) begin
            map_sdram = 1'b1;
            map_addr  = to_word(ioctl_addr, CHAR_START, CHAR_OFFSET);
        end else if (in_region(ioctl_addr, PROM_START, PROM_END)) begin
            map_prom = 1'b1;
            map_addr = sdram_addr_t'(ioctl_addr - PROM_START);  // Byte offset
        end
        if (map_sdram) map_mask = ioctl_addr[0] ? 2'b01 : 2'b10;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_sdram <= 1'b0;
            pend_prom  <= 1'b0;
            prog_we    <= 1'b0;
            prom_we    <= 1'b0;
        end else begin
            pend_sdram <= take && map_sdram;
            pend_prom  <= take && map_prom;  // Unmapped writes go nowhere
            prom_we    <= pend_prom;
            if (pend_sdram) prog_we <= 1'b1;
            else if (sdram_ack) prog_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && (map_sdram || map_prom)) prog <= '{addr: map_addr, data: ioctl_data,
                                                       mask: map_mask};
    end

endmodule

/* source/dd2_rom_slot.sv */
// ROM read slot with a one-word cache; instantiate once per CPU or video reader
module dd2_rom_slot #(
    parameter int                       AW     = 16,
    parameter dd2_rom_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cs,
    input  logic [AW-1:0]          addr,
    input  logic                   req_ready,
    input  dd2_rom_pkg::rom_rsp_t  rsp,
    output logic                   ok,
    output dd2_rom_pkg::rom_byte_t data,
    output dd2_rom_pkg::rom_req_t  req
);
    import dd2_rom_pkg::*;

    sdram_data_t cache_data;
    sdram_addr_t cache_tag;
    logic        cache_valid;
    sdram_addr_t word_addr;
    sdram_addr_t req_addr;
    logic        req_valid;
    logic        wait_rsp;  // Request taken, word not back yet
    logic        hit;
    rom_byte_t   hit_byte;

    // Byte address to the even SDRAM word that starts its 32-bit burst
    assign word_addr = OFFSET + sdram_addr_t'({addr[AW-1:2], 1'b0});
    assign hit       = cache_valid && (cache_tag == word_addr);
    assign hit_byte  = cache_data[{addr[1:0], 3'b000} +: 8];  // Byte 0 in bits 7:0

    assign req = '{valid: req_valid, addr: req_addr};

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_valid <= 1'b0;
            req_valid   <= 1'b0;
            wait_rsp    <= 1'b0;
            ok          <= 1'b0;
        end else begin
            ok <= cs && hit;
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
                wait_rsp  <= 1'b1;
            end else if (!req_valid && !wait_rsp && cs && !hit) begin
                req_valid <= 1'b1;
            end
            // Stale words from before a reset are dropped here
            if (wait_rsp && rsp.valid) begin
                wait_rsp    <= 1'b0;
                cache_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        data <= hit_byte;
        if (!req_valid && !wait_rsp) req_addr <= word_addr;  // Frozen until refill
        if (wait_rsp && rsp.valid) begin
            cache_data <= rsp.data;
            cache_tag  <= req_addr;
        end
    end

endmodule

/* source/dd2_sdram_arbiter.sv */
// Fixed-priority SDRAM read arbiter for the ROM slots; one read in flight at a time
module dd2_sdram_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  dd2_rom_pkg::rom_req_t    main_req,
    input  dd2_rom_pkg::rom_req_t    snd_req,
    input  dd2_rom_pkg::rom_req_t    char_req,
    input  logic                     sdram_ack,
    input  logic                     data_rdy,
    input  dd2_rom_pkg::sdram_data_t data_read,
    output logic                     main_ready,
    output logic                     snd_ready,
    output logic                     char_ready,
    output dd2_rom_pkg::rom_rsp_t    main_rsp,
    output dd2_rom_pkg::rom_rsp_t    snd_rsp,
    output dd2_rom_pkg::rom_rsp_t    char_rsp,
    output logic                     sdram_req,
    output dd2_rom_pkg::sdram_addr_t sdram_addr
);
    import dd2_rom_pkg::*;

    arb_state_t  state;
    logic [2:0]  grant;      // One-hot; bit 0 main, bit 1 sound, bit 2 char
    logic [2:0]  valid_vec;
    logic [2:0]  pick;
    sdram_addr_t pick_addr;
    logic        idle_en;
    logic        rsp_fire;

    assign valid_vec = {char_req.valid, snd_req.valid, main_req.valid};
    assign idle_en   = (state == IDLE) && enable;

    // Main wins over sound, sound over char
    assign pick[0] = valid_vec[0];
    assign pick[1] = valid_vec[1] && !valid_vec[0];
    assign pick[2] = valid_vec[2] && !valid_vec[1] && !valid_vec[0];

    always_comb begin
        if (pick[0]) pick_addr = main_req.addr;
        else if (pick[1]) pick_addr = snd_req.addr;
        else pick_addr = char_req.addr;
    end

    assign main_ready = idle_en;
    assign snd_ready  = idle_en && !main_req.valid;
    assign char_ready = idle_en && !main_req.valid && !snd_req.valid;

    // Read word goes straight back to the slot that asked for it
    assign rsp_fire = (state == WAIT_DATA) && data_rdy;
    assign main_rsp = '{valid: rsp_fire && grant[0], data: data_read};
    assign snd_rsp  = '{valid: rsp_fire && grant[1], data: data_read};
    assign char_rsp = '{valid: rsp_fire && grant[2], data: data_read};

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            grant     <= 3'b000;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (idle_en && (valid_vec != 3'b000)) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: if (data_rdy) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Address is loaded in IDLE and held with sdram_req
    always_ff @(posedge clk) begin
        if (state == IDLE) sdram_addr <= pick_addr;
    end

endmodule

/* source/dd2_rom_top.sv */
// ROM side of the game core; joins download remap, read slots, SDRAM arbiter and game reset
module dd2_rom_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                downloading,
    input  logic                                ioctl_wr,
    input  dd2_rom_pkg::ioctl_addr_t            ioctl_addr,
    input  dd2_rom_pkg::rom_byte_t              ioctl_data,
    input  logic                                sdram_ack,
    input  logic                                data_rdy,
    input  dd2_rom_pkg::sdram_data_t            data_read,
    input  logic                                main_cs,
    input  logic                                snd_cs,
    input  logic                                char_cs,
    input  logic [dd2_rom_pkg::MAIN_AW-1:0]     main_addr,
    input  logic [dd2_rom_pkg::SND_AW-1:0]      snd_addr,
    input  logic [dd2_rom_pkg::CHAR_AW-1:0]     char_addr,
    output logic                                ioctl_ready,
    output dd2_rom_pkg::prog_wr_t               prog,
    output logic                                prog_we,
    output logic                                prom_we,
    output logic                                sdram_req,
    output dd2_rom_pkg::sdram_addr_t            sdram_addr,
    output logic                                main_ok,
    output logic                                snd_ok,
    output logic                                char_ok,
    output dd2_rom_pkg::rom_byte_t              main_data,
    output dd2_rom_pkg::rom_byte_t              snd_data,
    output dd2_rom_pkg::rom_byte_t              char_data,
    output logic                                rom_ready,
    output logic                                rst_game
);
    import dd2_rom_pkg::*;

    rom_req_t main_req, snd_req, char_req;
    rom_rsp_t main_rsp, snd_rsp, char_rsp;
    logic     main_ready, snd_ready, char_ready;
    logic     ready_q;
    logic     rst_aux;   // First stage of the game reset
    logic     slot_rst;
    logic     prog_ack;
    logic     arb_ack;

    // Only a pending download write owns the acknowledge
    assign prog_ack = sdram_ack && prog_we;
    assign arb_ack  = sdram_ack && !prog_we;

    assign slot_rst  = rst || downloading;  // Cached words are stale after a download
    assign rom_ready = ready_q && !downloading;

    always_ff @(posedge clk) begin
        if (rst) ready_q <= 1'b0;
        else ready_q <= !downloading;
    end

    always_ff @(posedge clk) begin
        if (rst || downloading || !rom_ready) begin
            rst_game <= 1'b1;
            rst_aux  <= 1'b1;
        end else begin
            rst_game <= rst_aux;
            rst_aux  <= 1'b0;
        end
    end

    dd2_prog_map u_prog (
        .clk(clk), .rst(rst), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
        .ioctl_data(ioctl_data), .sdram_ack(prog_ack), .ioctl_ready(ioctl_ready),
        .prog(prog), .prog_we(prog_we), .prom_we(prom_we)
    );

    dd2_rom_slot #(.AW(MAIN_AW), .OFFSET(MAIN_OFFSET)) u_main (
        .clk(clk), .rst(slot_rst), .cs(main_cs), .addr(main_addr), .req_ready(main_ready),
        .rsp(main_rsp), .ok(main_ok), .data(main_data), .req(main_req)
    );

    dd2_rom_slot #(.AW(SND_AW), .OFFSET(SND_OFFSET)) u_snd (
        .clk(clk), .rst(slot_rst), .cs(snd_cs), .addr(snd_addr), .req_ready(snd_ready),
        .rsp(snd_rsp), .ok(snd_ok), .data(snd_data), .req(snd_req)
    );

    dd2_rom_slot #(.AW(CHAR_AW), .OFFSET(CHAR_OFFSET)) u_char (
        .clk(clk), .rst(slot_rst), .cs(char_cs), .addr(char_addr), .req_ready(char_ready),
        .rsp(char_rsp), .ok(char_ok), .data(char_data), .req(char_req)
    );

    dd2_sdram_arbiter u_arb (
        .clk(clk), .rst(rst), .enable(rom_ready),
        .main_req(main_req), .snd_req(snd_req), .char_req(char_req),
        .sdram_ack(arb_ack), .data_rdy(data_rdy), .data_read(data_read),
        .main_ready(main_ready), .snd_ready(snd_ready), .char_ready(char_ready),
        .main_rsp(main_rsp), .snd_rsp(snd_rsp), .char_rsp(char_rsp),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr)
    );

endmodule

/* test/sdram_model.sv */
// Behavioural SDRAM for the ROM testbench; acknowledges reads and download writes after random delays
module sdram_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sdram_req,
    input  dd2_rom_pkg::sdram_addr_t sdram_addr,
    input  logic                     prog_we,
    output logic                     sdram_ack,
    output logic                     data_rdy,
    output dd2_rom_pkg::sdram_data_t data_read
);
    timeunit 1ns;
    timeprecision 1ps;
    import dd2_rom_pkg::*;

    localparam sdram_data_t PATTERN = 32'hA5C3_0F96;  // Read data is word address XOR this

    logic        is_read;
    sdram_addr_t rd_addr;

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
    end

    // One access at a time; outputs move only on falling edges
    always begin
        @(negedge clk);
        if (!rst && (sdram_req || prog_we)) begin
            is_read = sdram_req;
            rd_addr = sdram_addr;
            repeat ($urandom_range(4, 1) - 1) @(negedge clk);
            sdram_ack = 1'b1;  // Single-cycle acknowledge
            @(negedge clk);
            sdram_ack = 1'b0;
            if (is_read) begin
                repeat ($urandom_range(3, 1) - 1) @(negedge clk);
                data_read = {10'b0, rd_addr} ^ PATTERN;
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy = 1'b0;
            end
        end
    end

endmodule

/* test/dd2_rom_tb.sv */
// Testbench for the ROM side of the game core; runs download and read tables against the SDRAM model
module dd2_rom_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dd2_rom_pkg::*;

    localparam logic [1:0] K_SDRAM = 2'd0;
    localparam logic [1:0] K_PROM  = 2'd1;
    localparam logic [1:0] K_NONE  = 2'd2;
    localparam int DL_N   = 10;
    localparam int RD_N   = 9;
    localparam int CONC_N = 4;
    localparam int LIMIT_CYCLES = (DL_N + RD_N + CONC_N) * 200 + 100;

    typedef struct packed {
        ioctl_addr_t addr;
        rom_byte_t   data;
        logic [1:0]  kind;
        sdram_addr_t exp_addr;  // Word address, or byte offset for the PROM
        logic [1:0]  exp_mask;
    } dl_entry_t;

    typedef struct packed {
        logic [1:0]  slot;       // 0 main, 1 sound, 2 char
        logic [17:0] addr;
        logic        same_word;  // Expect a cache hit
    } rd_entry_t;

    dl_entry_t dl_tab [DL_N] = '{
        '{22'h000000, 8'h11, K_SDRAM, 22'h000000, 2'b10},
        '{22'h012345, 8'h22, K_SDRAM, 22'h0091A2, 2'b01},
        '{22'h028001, 8'h33, K_SDRAM, 22'h014000, 2'b01},
        '{22'h02FFFE, 8'h44, K_SDRAM, 22'h017FFF, 2'b10},
        '{22'h080010, 8'h55, K_SDRAM, 22'h040008, 2'b10},
        '{22'h08FFFF, 8'h66, K_SDRAM, 22'h047FFF, 2'b01},
        '{22'h190000, 8'h77, K_PROM,  22'h000000, 2'b00},
        '{22'h1900FF, 8'h88, K_PROM,  22'h0000FF, 2'b00},
        '{22'h030000, 8'h99, K_NONE,  22'h000000, 2'b00},  // Gap after sound
        '{22'h1A0000, 8'hAA, K_NONE,  22'h000000, 2'b00}
    };

    rd_entry_t rd_tab [RD_N] = '{
        '{2'd0, 18'h00000, 1'b0},
        '{2'd0, 18'h00003, 1'b1},
        '{2'd0, 18'h2A5B6, 1'b0},
        '{2'd1, 18'h00001, 1'b0},
        '{2'd1, 18'h07FFE, 1'b0},
        '{2'd1, 18'h07FFF, 1'b1},
        '{2'd2, 18'h01234, 1'b0},
        '{2'd2, 18'h01236, 1'b1},
        '{2'd2, 18'h0FFFD, 1'b0}
    };

    logic clk, rst, downloading, ioctl_wr, ioctl_ready, prog_we, prom_we;
    logic sdram_ack, data_rdy, sdram_req, rom_ready, rst_game;
    logic main_cs, snd_cs, char_cs, main_ok, snd_ok, char_ok;
    logic [MAIN_AW-1:0] main_addr;
    logic [SND_AW-1:0]  snd_addr;
    logic [CHAR_AW-1:0] char_addr;
    ioctl_addr_t ioctl_addr;
    rom_byte_t   ioctl_data, main_data, snd_data, char_data;
    sdram_data_t data_read;
    sdram_addr_t sdram_addr;
    prog_wr_t    prog, last_prog, last_prom;
    logic        req_q = 1'b0;
    logic        prog_q = 1'b0;
    int          req_cnt = 0;
    int          prog_cnt = 0;
    int          prom_cnt = 0;

    dd2_rom_top UUT (
        .clk(clk), .rst(rst), .downloading(downloading), .ioctl_wr(ioctl_wr),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read), .main_cs(main_cs), .snd_cs(snd_cs),
        .char_cs(char_cs), .main_addr(main_addr), .snd_addr(snd_addr), .char_addr(char_addr),
        .ioctl_ready(ioctl_ready), .prog(prog), .prog_we(prog_we), .prom_we(prom_we),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .main_ok(main_ok), .snd_ok(snd_ok),
        .char_ok(char_ok), .main_data(main_data), .snd_data(snd_data), .char_data(char_data),
        .rom_ready(rom_ready), .rst_game(rst_game)
    );

    sdram_model u_sdram (
        .clk(clk), .rst(rst), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
        .prog_we(prog_we), .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

    always #4 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Byte of the 32-bit burst that holds the slot's byte address
    function automatic rom_byte_t pattern_byte(input logic [1:0] slot, input logic [17:0] addr);
        logic [22:0] byte_addr;
        sdram_data_t word;
        case (slot)
            2'd0: byte_addr = {MAIN_OFFSET, 1'b0} + 23'(addr[MAIN_AW-1:0]);
            2'd1: byte_addr = {SND_OFFSET, 1'b0} + 23'(addr[SND_AW-1:0]);
            default: byte_addr = {CHAR_OFFSET, 1'b0} + 23'(addr[CHAR_AW-1:0]);
        endcase
        word = {10'b0, byte_addr[22:2], 1'b0} ^ 32'hA5C3_0F96;
        return rom_byte_t'(word >> {byte_addr[1:0], 3'b000});
    endfunction

    function automatic logic slot_ok(input logic [1:0] slot);
        return (slot == 2'd0) ? main_ok : (slot == 2'd1) ? snd_ok : char_ok;
    endfunction

    function automatic rom_byte_t slot_data(input logic [1:0] slot);
        return (slot == 2'd0) ? main_data : (slot == 2'd1) ? snd_data : char_data;
    endfunction

    task automatic set_slot(input logic [1:0] slot, input logic cs, input logic [17:0] addr);
        case (slot)
            2'd0: begin
                main_cs   = cs;
                main_addr = addr[MAIN_AW-1:0];
            end
            2'd1: begin
                snd_cs   = cs;
                snd_addr = addr[SND_AW-1:0];
            end
            default: begin
                char_cs   = cs;
                char_addr = addr[CHAR_AW-1:0];
            end
        endcase
    endtask

    // Edge counters and captured write buses, sampled before the edge updates them
    always @(posedge clk) begin
        req_q  <= sdram_req;
        prog_q <= prog_we;
        if (sdram_req && !req_q) req_cnt <= req_cnt + 1;
        if (prog_we && !prog_q) begin
            prog_cnt  <= prog_cnt + 1;
            last_prog <= prog;
        end
        if (prom_we) begin
            prom_cnt  <= prom_cnt + 1;
            last_prom <= prog;
            check_value(32'(ioctl_ready), 1, "ioctl_ready during prom_we");
        end
        if (downloading && !rst) begin
            check_value(32'(rom_ready), 0, "rom_ready during download");
            check_value(32'(rst_game), 1, "rst_game during download");
        end
    end

    task automatic apply_download(input dl_entry_t e);
        int prog_before;
        int prom_before;
        prog_before = prog_cnt;
        prom_before = prom_cnt;
        while (!ioctl_ready) @(negedge clk);
        ioctl_wr   = 1'b1;
        ioctl_addr = e.addr;
        ioctl_data = e.data;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (e.kind == K_SDRAM) begin
            check_value(32'(ioctl_ready), 0, "ioctl_ready while write pending");
            while (prog_cnt == prog_before) @(negedge clk);
        end else if (e.kind == K_PROM) begin
            while (prom_cnt == prom_before) @(negedge clk);
        end
        repeat (3) @(negedge clk);  // Room for a stray strobe
        while (!ioctl_ready) @(negedge clk);
        check_value(prog_cnt - prog_before, (e.kind == K_SDRAM) ? 1 : 0, "prog_we writes");
        check_value(prom_cnt - prom_before, (e.kind == K_PROM) ? 1 : 0, "prom_we strobes");
        if (e.kind == K_SDRAM) begin
            check_value(32'(last_prog.addr), 32'(e.exp_addr), "prog address");
            check_value(32'(last_prog.data), 32'(e.data), "prog data");
            check_value(32'(last_prog.mask), 32'(e.exp_mask), "prog mask");
        end else if (e.kind == K_PROM) begin
            check_value(32'(last_prom.addr), 32'(e.exp_addr), "PROM offset");
            check_value(32'(last_prom.data), 32'(e.data), "PROM data");
            check_value(32'(last_prom.mask), 0, "PROM mask");
        end
    endtask

    task automatic apply_read(input rd_entry_t e);
        int reqs_before;
        int waited;
        reqs_before = req_cnt;
        waited = 0;
        set_slot(e.slot, 1'b1, e.addr);
        do begin
            @(negedge clk);
            waited++;
        end while (!slot_ok(e.slot));
        check_value(32'(slot_data(e.slot)), 32'(pattern_byte(e.slot, e.addr)), "slot byte");
        if (e.same_word) begin
            check_value(req_cnt - reqs_before, 0, "sdram_req count on cache hit");
            check_value(waited, 1, "cache hit latency");
        end else begin
            check_value(req_cnt - reqs_before, 1, "sdram_req count on cache miss");
        end
        set_slot(e.slot, 1'b0, e.addr);
        @(negedge clk);
    endtask

    // All three slots at once, random addresses
    task automatic apply_concurrent();
        logic [31:0] r;
        logic [17:0] a [3];
        for (int s = 0; s < 3; s++) begin
            r = $urandom;
            a[s] = r[17:0];
            set_slot(2'(s), 1'b1, a[s]);
        end
        while (!(main_ok && snd_ok && char_ok)) @(negedge clk);
        for (int s = 0; s < 3; s++) begin
            check_value(32'(slot_data(2'(s))), 32'(pattern_byte(2'(s), a[s])), "shared read");
            set_slot(2'(s), 1'b0, a[s]);
        end
        @(negedge clk);
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d cycles", LIMIT_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int cycles;
        void'($urandom(32'h69b1bed0));
        clk = 1'b0;
        rst = 1'b1;
        downloading = 1'b1;  // Download starts straight out of reset
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        main_cs = 1'b0;
        snd_cs = 1'b0;
        char_cs = 1'b0;
        main_addr = '0;
        snd_addr = '0;
        char_addr = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_value(32'({sdram_req, prog_we, prom_we}), 0, "request strobes after reset");
        check_value(32'({main_ok, snd_ok, char_ok}), 0, "ok flags after reset");
        check_value(32'(rst_game), 1, "rst_game after reset");
        check_value(32'(rom_ready), 0, "rom_ready after reset");
        foreach (dl_tab[i]) apply_download(dl_tab[i]);
        downloading = 1'b0;
        cycles = 0;
        while (!(rom_ready && !rst_game) && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        check_value(32'(rom_ready), 1, "rom_ready after download");
        check_value(32'(rst_game), 0, "rst_game after download");
        foreach (rd_tab[i]) apply_read(rd_tab[i]);
        repeat (CONC_N) apply_concurrent();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* dd2_rom_top.f */
source/dd2_rom_pkg.sv
source/dd2_prog_map.sv
source/dd2_rom_slot.sv
source/dd2_sdram_arbiter.sv
source/dd2_rom_top.sv
test/sdram_model.sv
test/dd2_rom_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= dd2_rom_tb
FILELIST   ?= dd2_rom_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) $(LINT_FLAGS) \
		-f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --timescale $(TIMESCALE) $(SIM_FLAGS) \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
